//--- flist.f
+incdir+.
rf_pkg.sv
rf_mem_3r1w_sync.sv
rf_bypass_file.sv
instr_decode.sv
operand_issue.sv
rf_read_stage.sv
rf_read_stage_sva.sv
tb_rf_read_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the operand read stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module tb_rf_read_stage -f flist.f
./obj_dir/Vtb_rf_read_stage | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
echo "simulation log is clean"

//--- tb_rf_read_stage.sv
// operand read stage testbench
`timescale 1ns/100ps
`default_nettype none

`include "rf_macros.svh"

module tb_rf_read_stage;

  import rf_pkg::*;

  // one table row, rnd rows draw op, addresses and data from the lfsr
  typedef struct packed {
    logic                  iv;
    rf_op_e                op;
    logic [`RF_ADDR_W-1:0] rd;
    logic [`RF_ADDR_W-1:0] rs1;
    logic [`RF_ADDR_W-1:0] rs2;
    logic [`RF_ADDR_W-1:0] rs3;
    logic                  wv;
    logic [`RF_ADDR_W-1:0] waddr;
    logic [`RF_DATA_W-1:0] wdata;
    logic                  rnd;
  } row_s;

  logic      clk;
  logic      reset;
  logic      instr_v;
  rf_instr_s instr;
  rf_write_s wb;
  logic      issue_v;
  rf_issue_s issue;

  row_s  rows[$];
  string names[$];

  // reference register file and the last address read on each port
  logic [`RF_DATA_W-1:0] ref_rf [`RF_ELS];
  logic [`RF_ADDR_W-1:0] held_addr [`RF_NUM_RS];
  logic [31:0]           lfsr;
  logic                  verdict_done;
  int                    n_checks;
  int                    n_errs;
  int                    n_tests;
  int                    n_bad_tests;
  int                    test_errs;
  string                 cur_test;

  rf_read_stage i_rf_read_stage (
    .clk_i     (clk),
    .reset_i   (reset),
    .instr_v_i (instr_v),
    .instr_i   (instr),
    .wb_i      (wb),
    .issue_v_o (issue_v),
    .issue_o   (issue)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ====================
  // helpers
  // ====================

  // galois form, taps for x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken, msb first
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] w;
    w = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[30:0], lfsr[0]};
    end
    return w;
  endfunction

  // sources each opcode reads, bit 0 is rs1
  function automatic logic [2:0] uses_of(input rf_op_e op);
    case (op)
      op_imm:  return 3'b001;
      op_reg:  return 3'b011;
      op_fma:  return 3'b111;
      default: return 3'b000;
    endcase
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errs++;
      test_errs++;
      $display("MISMATCH %s %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic close_test();
    n_tests++;
    if (test_errs == 0) begin
      $display("test %s: ok", cur_test);
    end else begin
      n_bad_tests++;
      $display("test %s: %0d errors", cur_test, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic add_row(input string name, input logic iv, input rf_op_e op,
                         input logic [4:0] rd, input logic [4:0] rs1,
                         input logic [4:0] rs2, input logic [4:0] rs3,
                         input logic wv, input logic [4:0] waddr, input logic [31:0] wdata);
    row_s r;
    r = {iv, op, rd, rs1, rs2, rs3, wv, waddr, wdata, 1'b0};
    names.push_back(name);
    rows.push_back(r);
  endtask

  task automatic add_random(input string name, input int n);
    row_s r;
    r     = '0;
    r.iv  = 1'b1;
    r.wv  = 1'b1;
    r.rnd = 1'b1;
    for (int j = 0; j < n; j++) begin
      names.push_back(name);
      rows.push_back(r);
    end
  endtask

  task automatic draw_random(inout row_s r);
    r.op    = rf_op_e'(2'(take_bits(2)));
    r.rd    = 5'(take_bits(5));
    r.rs1   = 5'(take_bits(5));
    r.rs2   = 5'(take_bits(5));
    r.rs3   = 5'(take_bits(5));
    r.waddr = 5'(take_bits(5));
    r.wdata = take_bits(32);
  endtask

  // ====================
  // stimulus table
  // ====================

  task automatic build_table();
    add_row("reset",  1'b0, op_nop, 5'd0,  5'd0, 5'd0, 5'd0, 1'b0, 5'd0, 32'h0);
    add_row("fill",   1'b0, op_nop, 5'd0,  5'd0, 5'd0, 5'd0, 1'b1, 5'd1, 32'h1111_0001);
    add_row("fill",   1'b0, op_nop, 5'd0,  5'd0, 5'd0, 5'd0, 1'b1, 5'd2, 32'h2222_0002);
    add_row("fill",   1'b0, op_nop, 5'd0,  5'd0, 5'd0, 5'd0, 1'b1, 5'd3, 32'h3333_0003);
    add_row("fill",   1'b0, op_nop, 5'd0,  5'd0, 5'd0, 5'd0, 1'b1, 5'd5, 32'h5555_0005);
    add_row("basic",  1'b1, op_reg, 5'd4,  5'd1, 5'd2, 5'd0, 1'b0, 5'd0, 32'h0);
    add_row("basic",  1'b1, op_fma, 5'd6,  5'd1, 5'd2, 5'd3, 1'b0, 5'd0, 32'h0);
    add_row("basic",  1'b1, op_imm, 5'd7,  5'd5, 5'd9, 5'd9, 1'b0, 5'd0, 32'h0);
    // write and read of one register at the same edge
    add_row("bypass", 1'b1, op_reg, 5'd10, 5'd8, 5'd1, 5'd0, 1'b1, 5'd8, 32'hcafe_0008);
    add_row("bypass", 1'b1, op_fma, 5'd11, 5'd9, 5'd9, 5'd9, 1'b1, 5'd9, 32'hcafe_0009);
    // x0 write is dropped, even when read in the same cycle
    add_row("reg0",   1'b1, op_fma, 5'd12, 5'd0, 5'd0, 5'd0, 1'b1, 5'd0, 32'hdead_beef);
    add_row("reg0",   1'b1, op_reg, 5'd13, 5'd0, 5'd2, 5'd0, 1'b0, 5'd0, 32'h0);
    add_row("hold",   1'b1, op_fma, 5'd14, 5'd1, 5'd2, 5'd3, 1'b0, 5'd0, 32'h0);
    add_row("hold",   1'b0, op_nop, 5'd0,  5'd0, 5'd0, 5'd0, 1'b0, 5'd0, 32'h0);
    add_row("hold",   1'b1, op_nop, 5'd15, 5'd7, 5'd7, 5'd7, 1'b0, 5'd0, 32'h0);
    add_row("hold",   1'b0, op_nop, 5'd0,  5'd0, 5'd0, 5'd0, 1'b0, 5'd0, 32'h0);
    // held ports 1,2,3 get patched, then port 0 moves to x4 while x1 is written
    add_row("patch",  1'b0, op_nop, 5'd0,  5'd0, 5'd0, 5'd0, 1'b1, 5'd2, 32'h2222_beef);
    add_row("patch",  1'b0, op_nop, 5'd0,  5'd0, 5'd0, 5'd0, 1'b1, 5'd3, 32'h3333_beef);
    add_row("patch",  1'b1, op_imm, 5'd16, 5'd4, 5'd0, 5'd0, 1'b1, 5'd1, 32'h1111_beef);
    add_row("patch",  1'b0, op_nop, 5'd0,  5'd0, 5'd0, 5'd0, 1'b1, 5'd4, 32'h4444_beef);
    add_row("patch",  1'b0, op_nop, 5'd0,  5'd0, 5'd0, 5'd0, 1'b0, 5'd0, 32'h0);
    add_random("random", 24);
    add_row("drain",  1'b0, op_nop, 5'd0,  5'd0, 5'd0, 5'd0, 1'b0, 5'd0, 32'h0);
  endtask

  // ====================
  // reference model and checks
  // ====================

  // row effect as seen after the edge that samples it
  task automatic apply_to_model(input row_s r);
    logic [2:0] u;
    u = uses_of(r.op);
    if (r.wv && r.waddr != '0) begin
      ref_rf[r.waddr] = r.wdata;
    end
    if (r.iv) begin
      if (u[0]) held_addr[0] = r.rs1;
      if (u[1]) held_addr[1] = r.rs2;
      if (u[2]) held_addr[2] = r.rs3;
    end
  endtask

  // p is the row sampled one edge before the current outputs
  task automatic check_outputs(input row_s p);
    logic [2:0] u;
    u = uses_of(p.op);
    check_val("issue_v", 32'(p.iv), 32'(issue_v));
    if (p.iv) begin
      check_val("op", 32'(p.op), 32'(issue.op));
      check_val("rd", 32'(p.rd), 32'(issue.rd));
      check_val("use", 32'(u), 32'(issue.use_rs));
    end
    // idle cycles and nops check every port, each port shows its held register
    for (int i = 0; i < `RF_NUM_RS; i++) begin
      if (!p.iv || p.op == op_nop || u[i]) begin
        check_val($sformatf("opnd%0d", i), ref_rf[held_addr[i]], issue.opnd[i]);
      end
    end
  endtask

  initial begin : stimulus
    row_s r;
    row_s last;
    build_table();
    lfsr         = 32'h433c99ba;
    verdict_done = 1'b0;
    n_checks     = 0;
    n_errs       = 0;
    n_tests      = 0;
    n_bad_tests  = 0;
    test_errs    = 0;
    cur_test     = names[0];
    last         = '0;
    for (int i = 0; i < `RF_ELS; i++) begin
      ref_rf[i] = '0;
    end
    for (int i = 0; i < `RF_NUM_RS; i++) begin
      held_addr[i] = '0;
    end
    reset   = 1'b1;
    instr_v = 1'b0;
    instr   = '0;
    wb      = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // one row per cycle, the extra pass drives idle and checks the last row
    for (int k = 0; k <= rows.size(); k++) begin
      @(posedge clk);
      r = '0;
      if (k < rows.size()) begin
        r = rows[k];
        if (r.rnd) begin
          draw_random(r);
        end
      end
      instr_v <= r.iv;
      instr   <= '{op: r.op, rd: r.rd, rs1: r.rs1, rs2: r.rs2, rs3: r.rs3};
      wb      <= '{v: r.wv, addr: r.waddr, data: r.wdata};
      @(negedge clk);
      check_outputs(last);
      if (k == rows.size()) begin
        close_test();
      end else if (names[k] != cur_test) begin
        close_test();
        cur_test = names[k];
      end
      apply_to_model(r);
      last = r;
    end

    $display("%0d tests, %0d with errors, %0d checks, %0d mismatches",
             n_tests, n_bad_tests, n_checks, n_errs);
    verdict_done = 1'b1;
    if (n_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin : watchdog
    #1;
    #((rows.size() + 10) * 100);
    $display("timeout: the table did not finish within %0d cycles", rows.size() + 10);
    verdict_done = 1'b1;
    $display("sim failed");
    $finish;
  end

  // a failing assertion stops the run before the closing line
  final begin
    if (!verdict_done) begin
      $display("sim failed");
    end
  end

endmodule

`default_nettype wire

//--- rf_read_stage_sva.sv
// operand stage assertions
`timescale 1ns/100ps
`default_nettype none

`include "rf_macros.svh"

module rf_read_stage_sva (
  input logic                  clk_i,
  input logic                  reset_i,
  input rf_pkg::rf_instr_s     instr_i,
  input logic                  dec_v_i,
  input logic [`RF_NUM_RS-1:0] dec_use_i,
  input logic                  issue_v_i,
  input rf_pkg::rf_issue_s     issue_i
);

  // source addresses in read port order
  logic [`RF_NUM_RS-1:0][`RF_ADDR_W-1:0] rs_addr;

  assign rs_addr[0] = instr_i.rs1;
  assign rs_addr[1] = instr_i.rs2;
  assign rs_addr[2] = instr_i.rs3;

  // ====================
  // properties
  // ====================

  // nothing issues during or right after reset
  a_reset_quiet: assert property (@(posedge clk_i) reset_i |=> !issue_v_i)
    else $error("issue valid high after a reset cycle");

  // fixed one cycle latency, decode valid to issue valid
  a_issue_follows: assert property (@(posedge clk_i) disable iff (reset_i)
    issue_v_i == $past(dec_v_i))
    else $error("issue valid does not follow decode valid by one cycle");

  // a used x0 source always issues as zero
  for (genvar i = 0; i < `RF_NUM_RS; i++) begin : g_x0
    a_x0_zero: assert property (@(posedge clk_i) disable iff (reset_i)
      (dec_v_i && dec_use_i[i] && rs_addr[i] == '0) |=> issue_i.opnd[i] == '0)
      else $error("port %0d issued nonzero data for x0", i);
  end

endmodule

// bound to the top, where source addresses and issue outputs meet
bind rf_read_stage rf_read_stage_sva i_rf_read_stage_sva (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .instr_i   (instr_i),
  .dec_v_i   (dec_v),
  .dec_use_i (dec_use),
  .issue_v_i (issue_v_o),
  .issue_i   (issue_o)
);

`default_nettype wire

//--- rf_read_stage.sv
// operand read stage top
`timescale 1ns/100ps
`default_nettype none

`include "rf_macros.svh"

module rf_read_stage (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              instr_v_i,
  input  rf_pkg::rf_instr_s instr_i,
  input  rf_pkg::rf_write_s wb_i,
  output logic              issue_v_o,
  output rf_pkg::rf_issue_s issue_o
);

  import rf_pkg::*;

  // decoder to register file
  rf_read_req_s                          req;
  // decoder to issue register
  logic                                  dec_v;
  rf_op_e                                dec_op;
  logic [`RF_ADDR_W-1:0]                 dec_rd;
  logic [`RF_NUM_RS-1:0]                 dec_use;
  // register file to issue register
  logic [`RF_NUM_RS-1:0][`RF_DATA_W-1:0] r_data;

  instr_decode i_instr_decode (
    .instr_v_i (instr_v_i),
    .instr_i   (instr_i),
    .req_o     (req),
    .dec_v_o   (dec_v),
    .dec_op_o  (dec_op),
    .dec_rd_o  (dec_rd),
    .dec_use_o (dec_use)
  );

  // writeback goes straight in, no arbitration
  rf_bypass_file i_rf_bypass_file (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (req),
    .wb_i     (wb_i),
    .r_data_o (r_data)
  );

  operand_issue i_operand_issue (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .dec_v_i   (dec_v),
    .dec_op_i  (dec_op),
    .dec_rd_i  (dec_rd),
    .dec_use_i (dec_use),
    .r_data_i  (r_data),
    .issue_v_o (issue_v_o),
    .issue_o   (issue_o)
  );

endmodule

`default_nettype wire

//--- operand_issue.sv
// operand issue register
`timescale 1ns/100ps
`default_nettype none

`include "rf_macros.svh"

module operand_issue (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  dec_v_i,
  input  rf_pkg::rf_op_e                        dec_op_i,
  input  logic [`RF_ADDR_W-1:0]                 dec_rd_i,
  input  logic [`RF_NUM_RS-1:0]                 dec_use_i,
  input  logic [`RF_NUM_RS-1:0][`RF_DATA_W-1:0] r_data_i,
  output logic                                  issue_v_o,
  output rf_pkg::rf_issue_s                     issue_o
);

  import rf_pkg::*;

  logic                  v_r;
  rf_op_e                op_r;
  logic [`RF_ADDR_W-1:0] rd_r;
  logic [`RF_NUM_RS-1:0] use_r;

  // ====================
  // alignment stage
  // ====================

  // one cycle, same as the register file read latency
  // fields hold while idle, matching the held operands
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r   <= 1'b0;
      op_r  <= op_nop;
      rd_r  <= '0;
      use_r <= '0;
    end else begin
      v_r <= dec_v_i;
      if (dec_v_i) begin
        op_r  <= dec_op_i;
        rd_r  <= dec_rd_i;
        use_r <= dec_use_i;
      end
    end
  end

  // bundle the aligned fields with the read data
  always_comb begin
    issue_o.op     = op_r;
    issue_o.rd     = rd_r;
    issue_o.use_rs = use_r;
    issue_o.opnd   = r_data_i;
  end

  assign issue_v_o = v_r;

endmodule

`default_nettype wire

//--- instr_decode.sv
// instruction source decoder
`timescale 1ns/100ps
`default_nettype none

`include "rf_macros.svh"

module instr_decode (
  input  logic                  instr_v_i,
  input  rf_pkg::rf_instr_s     instr_i,
  output rf_pkg::rf_read_req_s  req_o,
  output logic                  dec_v_o,
  output rf_pkg::rf_op_e        dec_op_o,
  output logic [`RF_ADDR_W-1:0] dec_rd_o,
  output logic [`RF_NUM_RS-1:0] dec_use_o
);

  import rf_pkg::*;

  // bit 0 rs1, bit 1 rs2, bit 2 rs3
  logic [`RF_NUM_RS-1:0] use_rs;

  // ====================
  // source use map
  // ====================

  always_comb begin
    case (instr_i.op)
      op_nop:  use_rs = 3'b000;
      op_imm:  use_rs = 3'b001;
      op_reg:  use_rs = 3'b011;
      op_fma:  use_rs = 3'b111;
      default: use_rs = 3'b000;
    endcase
  end

  // ====================
  // read request
  // ====================

  // unused ports and idle cycles raise no valid, so held values stay put
  always_comb begin
    req_o.v       = use_rs & {`RF_NUM_RS{instr_v_i}};
    req_o.addr[0] = instr_i.rs1;
    req_o.addr[1] = instr_i.rs2;
    req_o.addr[2] = instr_i.rs3;
  end

  // side band to the issue register
  assign dec_v_o   = instr_v_i;
  assign dec_op_o  = instr_i.op;
  assign dec_rd_o  = instr_i.rd;
  assign dec_use_o = use_rs;

endmodule

`default_nettype wire

//--- rf_bypass_file.sv
// register file with bypass and hold
`timescale 1ns/100ps
`default_nettype none

`include "rf_macros.svh"

module rf_bypass_file (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  rf_pkg::rf_read_req_s                  req_i,
  input  rf_pkg::rf_write_s                     wb_i,
  output logic [`RF_NUM_RS-1:0][`RF_DATA_W-1:0] r_data_o
);

  // x0 writes are dropped before they reach the array
  logic                                  w_v_li;
  // same-cycle read and write of one register, per port
  logic [`RF_NUM_RS-1:0]                 rw_same_addr;
  // array read enables after bypass and x0 filtering
  logic [`RF_NUM_RS-1:0]                 r_v_li;
  logic [`RF_NUM_RS-1:0][`RF_DATA_W-1:0] r_data_lo;

  // write-through data, shared since there is only one write port
  logic [`RF_DATA_W-1:0]                 w_data_r;
  logic [`RF_DATA_W-1:0]                 w_data_n;
  logic [`RF_NUM_RS-1:0]                 rw_same_addr_r;
  logic [`RF_NUM_RS-1:0]                 r_v_r;
  // last address read on each port and the value held for it
  logic [`RF_NUM_RS-1:0][`RF_ADDR_W-1:0] r_addr_r;
  logic [`RF_NUM_RS-1:0][`RF_ADDR_W-1:0] r_addr_n;
  logic [`RF_NUM_RS-1:0][`RF_DATA_W-1:0] r_data_r;
  logic [`RF_NUM_RS-1:0][`RF_DATA_W-1:0] r_data_n;
  // fresh read result, array word or bypassed write
  logic [`RF_NUM_RS-1:0][`RF_DATA_W-1:0] r_safe_data;
  // value the port shows this cycle, before x0 forcing
  logic [`RF_NUM_RS-1:0][`RF_DATA_W-1:0] r_cur_data;

  // ====================
  // request side
  // ====================

  assign w_v_li = wb_i.v & (wb_i.addr != '0);

  for (genvar i = 0; i < `RF_NUM_RS; i++) begin : g_req
    assign rw_same_addr[i] = w_v_li & req_i.v[i] & (wb_i.addr == req_i.addr[i]);
    // skip the array on a bypass hit or an x0 read
    assign r_v_li[i] = req_i.v[i] & ~rw_same_addr[i] & (req_i.addr[i] != '0);
  end

  rf_mem_3r1w_sync i_rf_mem (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .w_v_i    (w_v_li),
    .w_addr_i (wb_i.addr),
    .w_data_i (wb_i.data),
    .r_v_i    (r_v_li),
    .r_addr_i (req_i.addr),
    .r_data_o (r_data_lo)
  );

  // ====================
  // hold and patch
  // ====================

  for (genvar i = 0; i < `RF_NUM_RS; i++) begin : g_hold
    assign r_safe_data[i] = rw_same_addr_r[i] ? w_data_r : r_data_lo[i];
    // fresh data in the cycle after a read, held value after that
    assign r_cur_data[i] = r_v_r[i] ? r_safe_data[i] : r_data_r[i];
    assign r_addr_n[i] = req_i.v[i] ? req_i.addr[i] : r_addr_r[i];
    // a write to the held address replaces the held value next cycle
    assign r_data_n[i] = (w_v_li & (r_addr_r[i] == wb_i.addr)) ? wb_i.data
                                                                : r_cur_data[i];
    // x0 always reads as zero
    assign r_data_o[i] = (r_addr_r[i] == '0) ? '0 : r_cur_data[i];
  end

  assign w_data_n = (|rw_same_addr) ? wb_i.data : w_data_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rw_same_addr_r <= '0;
      r_v_r          <= '0;
      w_data_r       <= '0;
      r_addr_r       <= '0;
      r_data_r       <= '0;
    end else begin
      rw_same_addr_r <= rw_same_addr;
      r_v_r          <= req_i.v;
      w_data_r       <= w_data_n;
      r_addr_r       <= r_addr_n;
      r_data_r       <= r_data_n;
    end
  end

endmodule

`default_nettype wire

//--- rf_mem_3r1w_sync.sv
// three read one write register array
`timescale 1ns/100ps
`default_nettype none

`include "rf_macros.svh"

module rf_mem_3r1w_sync (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  w_v_i,
  input  logic [`RF_ADDR_W-1:0]                 w_addr_i,
  input  logic [`RF_DATA_W-1:0]                 w_data_i,
  input  logic [`RF_NUM_RS-1:0]                 r_v_i,
  input  logic [`RF_NUM_RS-1:0][`RF_ADDR_W-1:0] r_addr_i,
  output logic [`RF_NUM_RS-1:0][`RF_DATA_W-1:0] r_data_o
);

  // flop array, one word per register
  logic [`RF_ELS-1:0][`RF_DATA_W-1:0] mem_r;
  // registered read data, one word per port
  logic [`RF_NUM_RS-1:0][`RF_DATA_W-1:0] r_data_r;

  // ====================
  // write port
  // ====================

  // cleared on reset so the first reads are defined
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_r <= '0;
    end else if (w_v_i) begin
      mem_r[w_addr_i] <= w_data_i;
    end
  end

  // ====================
  // read ports
  // ====================

  // each port samples the array word on its own valid, holds otherwise
  // a same-edge write is not visible here, the wrapper bypasses it
  for (genvar i = 0; i < `RF_NUM_RS; i++) begin : g_rd
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        r_data_r[i] <= '0;
      end else if (r_v_i[i]) begin
        r_data_r[i] <= mem_r[r_addr_i[i]];
      end
    end
  end

  assign r_data_o = r_data_r;

endmodule

`default_nettype wire

//--- rf_pkg.sv
// operand stage types
`default_nettype none

`include "rf_macros.svh"

package rf_pkg;

  // opcode class, only says how many sources are read
  typedef enum logic [1:0] {
    op_nop = 2'd0,
    op_imm = 2'd1,
    op_reg = 2'd2,
    op_fma = 2'd3
  } rf_op_e;

  // instruction word, 22 bits
  typedef struct packed {
    rf_op_e                op;
    logic [`RF_ADDR_W-1:0] rd;
    logic [`RF_ADDR_W-1:0] rs1;
    logic [`RF_ADDR_W-1:0] rs2;
    logic [`RF_ADDR_W-1:0] rs3;
  } rf_instr_s;

  // read request, index 0 is rs1, 18 bits
  typedef struct packed {
    logic [`RF_NUM_RS-1:0]                 v;
    logic [`RF_NUM_RS-1:0][`RF_ADDR_W-1:0] addr;
  } rf_read_req_s;

  // writeback port, 38 bits
  typedef struct packed {
    logic                  v;
    logic [`RF_ADDR_W-1:0] addr;
    logic [`RF_DATA_W-1:0] data;
  } rf_write_s;

  // issued operand bundle, 106 bits
  typedef struct packed {
    rf_op_e                                op;
    logic [`RF_ADDR_W-1:0]                 rd;
    logic [`RF_NUM_RS-1:0]                 use_rs;
    logic [`RF_NUM_RS-1:0][`RF_DATA_W-1:0] opnd;
  } rf_issue_s;

endpackage

`default_nettype wire

//--- rf_macros.svh
// register file sizes

`ifndef RF_MACROS_SVH
`define RF_MACROS_SVH

// ====================
// operand stage sizes
// ====================

// width of one architectural register
`define RF_DATA_W 32

// number of architectural registers, x0 included
`define RF_ELS 32

// register address width, clog2 of RF_ELS
`define RF_ADDR_W 5

// read ports, three so the fused multiply-add gets all its sources
`define RF_NUM_RS 3

`endif
